// ==== Makefile ====
.PHONY: help test clean

LOG := sim.log

help:
	@echo "make test   build tb_mmio with Verilator and run it"
	@echo "make clean  remove obj_dir and the simulation log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mmio -f all.f
	./obj_dir/Vtb_mmio | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+rtl
rtl/mmio_pkg.sv
rtl/ram.sv
rtl/kbd_fifo.sv
rtl/rtc_counter.sv
rtl/mmio.sv
rtl/mmio_top.sv
tests/tb_mmio.sv

// ==== rtl/kbd_fifo.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module kbd_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`KB_WIDTH-1:0] kb_code,
    input  logic                 kb_valid,
    input  logic                 sig_rd_kb,
    output logic [`KB_WIDTH-1:0] kb_rdata,
    output logic                 kb_ready
);

    localparam int PTR_W = $clog2(`KBD_DEPTH);

    logic [`KB_WIDTH-1:0] entries [`KBD_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full = (count == (PTR_W + 1)'(`KBD_DEPTH));
    assign push = kb_valid && !full;
    // a read pulse on an empty queue does nothing
    assign pop  = sig_rd_kb && kb_ready;

    assign kb_ready = (count != '0);
    assign kb_rdata = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= kb_code;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mmio.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module mmio (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`ADDR_WIDTH-1:0] mem_raddr,
    input  logic [`ADDR_WIDTH-1:0] mem_waddr,
    input  mmio_pkg::xlen_t        mem_wdata,
    input  logic                   mem_wen,
    input  logic                   mem_ren,
    input  mmio_pkg::wdt_op_e      wdt_op,
    input  logic [`KB_WIDTH-1:0]   kb_rdata,
    input  logic                   kb_ready,
    input  logic [`SWT_WIDTH-1:0]  swt_rdata,
    input  mmio_pkg::xlen_t        clkdiv,
    output mmio_pkg::xlen_t        mem_rdata,
    output logic                   sig_rd_kb,
    output logic [`SEG_WIDTH-1:0]  seg_wdata,
    output logic [`LED_WIDTH-1:0]  led_wdata
);
    import mmio_pkg::*;

    xlen_t ram_rdata;
    logic  ram_wen;

    logic  rd_ram;
    logic  rd_kbd;
    logic  rd_swt;
    logic  rd_rtc;
    logic  wr_ram;
    logic  wr_seg;
    logic  wr_led;

    function automatic logic in_win(
        input logic [`ADDR_WIDTH-1:0] addr,
        input logic [`ADDR_WIDTH-1:0] base,
        input logic [`ADDR_WIDTH-1:0] len
    );
        return (addr >= base) && ((addr - base) < len);
    endfunction

    // read side windows
    assign rd_ram = in_win(mem_raddr, `RAM_BASE, `RAM_LEN);
    assign rd_kbd = in_win(mem_raddr, `KBD_ADDR, `PERI_LEN);
    assign rd_swt = in_win(mem_raddr, `SWT_ADDR, `PERI_LEN);
    assign rd_rtc = in_win(mem_raddr, `RTC_ADDR, `PERI_LEN);

    // write side windows
    assign wr_ram = in_win(mem_waddr, `RAM_BASE, `RAM_LEN);
    assign wr_seg = in_win(mem_waddr, `SEG_ADDR, `PERI_LEN);
    assign wr_led = in_win(mem_waddr, `LED_ADDR, `PERI_LEN);

    assign ram_wen = mem_wen && wr_ram;

    ram u_ram (
        .clk    (clk),
        .raddr  (mem_raddr),
        .waddr  (mem_waddr),
        .wdata  (mem_wdata),
        .wen    (ram_wen),
        .wdt_op (wdt_op),
        .rdata  (ram_rdata)
    );

    // pop the queue only when an entry is actually handed out
    assign sig_rd_kb = mem_ren && rd_kbd && kb_ready;

    always_comb begin
        mem_rdata = '0;
        if (mem_ren) begin
            if (rd_ram) begin
                mem_rdata = ram_rdata;
            end else if (rd_kbd) begin
                if (kb_ready) begin
                    mem_rdata = xlen_t'(kb_rdata);
                end
            end else if (rd_swt) begin
                mem_rdata = xlen_t'(swt_rdata);
            end else if (rd_rtc) begin
                mem_rdata = clkdiv;
            end
        end
    end

    // display and LED registers, out-of-map writes fall through
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg_wdata <= '0;
            led_wdata <= '0;
        end else if (mem_wen) begin
            if (wr_seg) begin
                seg_wdata <= mem_wdata[`SEG_WIDTH-1:0];
            end
            if (wr_led) begin
                led_wdata <= mem_wdata[`LED_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== rtl/mmio_pkg.sv ====
`include "soc_cfg.svh"

package mmio_pkg;

    // one data word on the core-side port
    typedef logic [`XLEN-1:0] xlen_t;

    // load/store width, the U variants zero-extend on load
    typedef enum logic [2:0] {
        WDT_B  = 3'd0,
        WDT_H  = 3'd1,
        WDT_W  = 3'd2,
        WDT_D  = 3'd3,
        WDT_BU = 3'd4,
        WDT_HU = 3'd5,
        WDT_WU = 3'd6
    } wdt_op_e;

endpackage

// ==== rtl/mmio_top.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module mmio_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`ADDR_WIDTH-1:0] mem_raddr,
    input  logic [`ADDR_WIDTH-1:0] mem_waddr,
    input  mmio_pkg::xlen_t        mem_wdata,
    input  logic                   mem_wen,
    input  logic                   mem_ren,
    input  mmio_pkg::wdt_op_e      wdt_op,
    input  logic [`KB_WIDTH-1:0]   kb_code,
    input  logic                   kb_valid,
    input  logic [`SWT_WIDTH-1:0]  swt_rdata,
    output mmio_pkg::xlen_t        mem_rdata,
    output logic [`SEG_WIDTH-1:0]  seg_wdata,
    output logic [`LED_WIDTH-1:0]  led_wdata
);
    import mmio_pkg::*;

    logic [`KB_WIDTH-1:0] kb_rdata;
    logic                 kb_ready;
    logic                 sig_rd_kb;
    xlen_t                clkdiv;

    mmio u_mmio (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .wdt_op    (wdt_op),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .swt_rdata (swt_rdata),
        .clkdiv    (clkdiv),
        .mem_rdata (mem_rdata),
        .sig_rd_kb (sig_rd_kb),
        .seg_wdata (seg_wdata),
        .led_wdata (led_wdata)
    );

    // scan codes in, head entry out to the decoder
    kbd_fifo u_kbd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .kb_code   (kb_code),
        .kb_valid  (kb_valid),
        .sig_rd_kb (sig_rd_kb),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready)
    );

    rtc_counter u_rtc_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .clkdiv (clkdiv)
    );

endmodule

// ==== rtl/ram.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ram (
    input  logic                   clk,
    input  logic [`ADDR_WIDTH-1:0] raddr,
    input  logic [`ADDR_WIDTH-1:0] waddr,
    input  mmio_pkg::xlen_t        wdata,
    input  logic                   wen,
    input  mmio_pkg::wdt_op_e      wdt_op,
    output mmio_pkg::xlen_t        rdata
);
    import mmio_pkg::*;

    localparam int IDX_W   = $clog2(`RAM_DEPTH);
    localparam int OFS_W   = $clog2(`XLEN / 8);
    localparam int N_LANES = `XLEN / 8;

    xlen_t mem [`RAM_DEPTH];

    logic [IDX_W-1:0]   ridx;
    logic [IDX_W-1:0]   widx;
    xlen_t              rword;
    xlen_t              rshift;
    logic [N_LANES-1:0] lanes;
    logic [N_LANES-1:0] wmask;
    xlen_t              wshift;

    // word index sits just above the byte offset
    assign ridx = raddr[OFS_W +: IDX_W];
    assign widx = waddr[OFS_W +: IDX_W];

    assign rword  = mem[ridx];
    // bring the addressed lane down to bit 0
    assign rshift = rword >> {raddr[OFS_W-1:0], 3'b000};

    always_comb begin
        case (wdt_op)
            WDT_B:   rdata = {{(`XLEN-8){rshift[7]}}, rshift[7:0]};
            WDT_H:   rdata = {{(`XLEN-16){rshift[15]}}, rshift[15:0]};
            WDT_W:   rdata = {{(`XLEN-32){rshift[31]}}, rshift[31:0]};
            WDT_BU:  rdata = {{(`XLEN-8){1'b0}}, rshift[7:0]};
            WDT_HU:  rdata = {{(`XLEN-16){1'b0}}, rshift[15:0]};
            WDT_WU:  rdata = {{(`XLEN-32){1'b0}}, rshift[31:0]};
            default: rdata = rword;
        endcase
    end

    // stores only care about the width
    always_comb begin
        case (wdt_op)
            WDT_B, WDT_BU: lanes = N_LANES'(8'h01);
            WDT_H, WDT_HU: lanes = N_LANES'(8'h03);
            WDT_W, WDT_WU: lanes = N_LANES'(8'h0f);
            default:       lanes = '1;
        endcase
    end

    assign wmask  = lanes << waddr[OFS_W-1:0];
    assign wshift = wdata << {waddr[OFS_W-1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < N_LANES; i++) begin
                if (wmask[i]) begin
                    mem[widx][i*8 +: 8] <= wshift[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/rtc_counter.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module rtc_counter (
    input  logic            clk,
    input  logic            rst_n,
    output mmio_pkg::xlen_t clkdiv
);
    import mmio_pkg::*;

    localparam int PRE_W = (`RTC_DIV > 1) ? $clog2(`RTC_DIV) : 1;

    logic [PRE_W-1:0] prescale;
    logic             tick;
    xlen_t            ticks;

    assign tick   = (prescale == PRE_W'(`RTC_DIV - 1));
    assign clkdiv = ticks;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale <= '0;
            ticks    <= '0;
        end else if (tick) begin
            prescale <= '0;
            ticks    <= ticks + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

// ==== rtl/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus and data widths
`define ADDR_WIDTH  32
`define XLEN        64

// device port widths
`define KB_WIDTH    8
`define SWT_WIDTH   8
`define SEG_WIDTH   32
`define LED_WIDTH   16

// data RAM window, 4 KiB of 64-bit words
`define RAM_BASE    32'h8000_0000
`define RAM_LEN     32'h0000_1000
`define RAM_DEPTH   512

// peripheral windows
`define RTC_ADDR    32'ha000_0048
`define KBD_ADDR    32'ha000_0060
`define SWT_ADDR    32'ha000_0070
`define SEG_ADDR    32'ha000_0080
`define LED_ADDR    32'ha000_0090
`define PERI_LEN    32'h0000_0008

// scan-code queue entries
`define KBD_DEPTH   8

// clk cycles per counter tick
`define RTC_DIV     4

`endif

// ==== tests/tb_mmio.sv ====
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_mmio;
    import mmio_pkg::*;

    localparam int LIMIT = 40000;

    logic                   clk;
    logic                   rst_n;
    logic [`ADDR_WIDTH-1:0] mem_raddr;
    logic [`ADDR_WIDTH-1:0] mem_waddr;
    xlen_t                  mem_wdata;
    logic                   mem_wen;
    logic                   mem_ren;
    wdt_op_e                wdt_op;
    logic [`KB_WIDTH-1:0]   kb_code;
    logic                   kb_valid;
    logic [`SWT_WIDTH-1:0]  swt_rdata;
    xlen_t                  mem_rdata;
    logic [`SEG_WIDTH-1:0]  seg_wdata;
    logic [`LED_WIDTH-1:0]  led_wdata;

    // reference state
    logic [7:0]            ram_model [`RAM_LEN];
    logic [`KB_WIDTH-1:0]  kbd_model [$];
    logic [`SEG_WIDTH-1:0] exp_seg = '0;
    logic [`LED_WIDTH-1:0] exp_led = '0;
    logic [31:0]           seed = 32'ha4df;
    int                    errors = 0;

    mmio_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        for (int c = 0; c < LIMIT; c++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    // no read strobe, no data
    assert property (@(posedge clk) !mem_ren |-> mem_rdata == '0)
        else begin
            $display("Mismatch at %0t: mem_rdata got %h expected 0", $time, mem_rdata);
            errors++;
        end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int access_bytes(input wdt_op_e op);
        case (op)
            WDT_B, WDT_BU: return 1;
            WDT_H, WDT_HU: return 2;
            WDT_W, WDT_WU: return 4;
            default:       return 8;
        endcase
    endfunction

    // little endian gather from the byte model, then extend
    function automatic xlen_t expected_load(input logic [31:0] addr, input wdt_op_e op);
        int    nb;
        xlen_t val;
        nb  = access_bytes(op);
        val = '0;
        for (int i = 0; i < nb; i++) begin
            val[i*8 +: 8] = ram_model[int'(addr - `RAM_BASE) + i];
        end
        if ((op == WDT_B || op == WDT_H || op == WDT_W) && val[nb*8-1]) begin
            val = val | (~xlen_t'(0) << (nb * 8));
        end
        return val;
    endfunction

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t expected);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        errors++;
    endtask

    task automatic write_mem(input logic [31:0] addr, input xlen_t data, input wdt_op_e op);
        int nb;
        nb = access_bytes(op);
        @(negedge clk);
        mem_waddr = addr;
        mem_wdata = data;
        wdt_op    = op;
        mem_wen   = 1'b1;
        @(negedge clk);
        mem_wen = 1'b0;
        if (addr >= `RAM_BASE && addr - `RAM_BASE < `RAM_LEN) begin
            for (int i = 0; i < nb; i++) begin
                ram_model[int'(addr - `RAM_BASE) + i] = data[i*8 +: 8];
            end
        end
        if (addr == `SEG_ADDR) begin
            exp_seg = data[`SEG_WIDTH-1:0];
        end
        if (addr == `LED_ADDR) begin
            exp_led = data[`LED_WIDTH-1:0];
        end
        assert (seg_wdata == exp_seg)
            else report_mismatch("seg_wdata", xlen_t'(seg_wdata), xlen_t'(exp_seg));
        assert (led_wdata == exp_led)
            else report_mismatch("led_wdata", xlen_t'(led_wdata), xlen_t'(exp_led));
    endtask

    // one read cycle, so a keyboard read pops at most once
    task automatic read_check(input logic [31:0] addr, input wdt_op_e op, input xlen_t expected);
        @(negedge clk);
        mem_raddr = addr;
        wdt_op    = op;
        mem_ren   = 1'b1;
        #1;
        assert (mem_rdata == expected) else report_mismatch("mem_rdata", mem_rdata, expected);
        @(negedge clk);
        mem_ren = 1'b0;
    endtask

    task automatic push_code(input logic [`KB_WIDTH-1:0] code);
        @(negedge clk);
        kb_code  = code;
        kb_valid = 1'b1;
        @(negedge clk);
        kb_valid = 1'b0;
        if (kbd_model.size() < `KBD_DEPTH) begin
            kbd_model.push_back(code);
        end
    endtask

    task automatic read_kbd();
        xlen_t expected;
        expected = '0;
        if (kbd_model.size() > 0) begin
            expected = xlen_t'(kbd_model.pop_front());
        end
        read_check(`KBD_ADDR, WDT_D, expected);
    endtask

    task automatic sample_rtc(output xlen_t v);
        @(negedge clk);
        mem_raddr = `RTC_ADDR;
        mem_ren   = 1'b1;
        #1;
        v = mem_rdata;
    endtask

    initial begin
        xlen_t       v0;
        xlen_t       v1;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] base;
        wdt_op_e     op;
        int          nb;
        int          waited;

        rst_n     = 1'b0;
        mem_raddr = '0;
        mem_waddr = '0;
        mem_wdata = '0;
        mem_wen   = 1'b0;
        mem_ren   = 1'b0;
        wdt_op    = WDT_D;
        kb_code   = '0;
        kb_valid  = 1'b0;
        swt_rdata = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        assert (seg_wdata == '0) else report_mismatch("seg_wdata", xlen_t'(seg_wdata), '0);
        assert (led_wdata == '0) else report_mismatch("led_wdata", xlen_t'(led_wdata), '0);
        read_kbd();

        // fill pattern carries the whole word address
        for (int w = 0; w < `RAM_DEPTH; w++) begin
            addr = `RAM_BASE + 32'(w * 8);
            write_mem(addr, {addr, ~addr}, WDT_D);
        end

        // random store, then every load width across the same word
        for (int n = 0; n < 60; n++) begin
            r    = next_rand();
            op   = wdt_op_e'(r[2:0] % 3'd7);
            nb   = access_bytes(op);
            addr = `RAM_BASE + ((r >> 12) % (`RAM_LEN / nb)) * nb;
            write_mem(addr, {next_rand(), next_rand()}, op);
            base = {addr[31:3], 3'b000};
            for (int k = 0; k < 7; k++) begin
                op   = wdt_op_e'(k[2:0]);
                nb   = access_bytes(op);
                addr = base + 32'((int'(next_rand() >> 20) % (8 / nb)) * nb);
                read_check(addr, op, expected_load(addr, op));
            end
        end

        write_mem(`SEG_ADDR, {next_rand(), next_rand()}, WDT_D);
        write_mem(`LED_ADDR, {next_rand(), next_rand()}, WDT_D);
        write_mem(`RAM_BASE + 32'h40, {next_rand(), next_rand()}, WDT_D);
        write_mem(`SWT_ADDR, {next_rand(), next_rand()}, WDT_D);
        write_mem(32'h1000_0000, {next_rand(), next_rand()}, WDT_D);
        write_mem(`SEG_ADDR, {next_rand(), next_rand()}, WDT_W);

        // order, empty read, then overflow
        push_code(8'h1c);
        push_code(8'hf0);
        repeat (3) read_kbd();
        push_code(8'h5a);
        read_kbd();
        for (int n = 0; n < `KBD_DEPTH + 3; n++) begin
            r = next_rand();
            push_code(r[`KB_WIDTH-1:0]);
        end
        repeat (`KBD_DEPTH + 1) read_kbd();

        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            @(negedge clk);
            swt_rdata = r[`SWT_WIDTH-1:0];
            read_check(`SWT_ADDR, WDT_D, xlen_t'(r[`SWT_WIDTH-1:0]));
        end
        read_check(32'h0000_0000, WDT_D, '0);
        read_check(`RAM_BASE + `RAM_LEN, WDT_D, '0);
        read_check(`SEG_ADDR, WDT_D, '0);
        read_check(32'hffff_fff8, WDT_D, '0);

        // counter must move within a few prescaler periods
        sample_rtc(v0);
        v1     = v0;
        waited = 0;
        while (v1 == v0 && waited < 4 * `RTC_DIV) begin
            sample_rtc(v1);
            waited++;
        end
        assert (v1 != v0) else begin
            $display("counter did not advance within %0d cycles", waited);
            errors++;
        end
        for (int k = 1; k < 24; k += 3) begin
            sample_rtc(v0);
            repeat (k - 1) @(negedge clk);
            sample_rtc(v1);
            assert (v1 >= v0 && v1 - v0 >= xlen_t'(k / `RTC_DIV)
                    && v1 - v0 <= xlen_t'(k / `RTC_DIV + 1)) else begin
                $display("counter moved from %0d to %0d over %0d cycles", v0, v1, k);
                errors++;
            end
        end
        @(negedge clk);
        mem_ren = 1'b0;
        @(negedge clk);

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
